// File: piso_pkg.sv
// piso shared definitions: buffer style, word order and default sizes
package piso_pkg;

    // style of the buffer that holds the last word of a frame
    typedef enum logic [0:0]
    {
        // two entries, next frame loads while the last word waits
        BUF_TWO = 1'b0,
        // one entry, smaller but one idle cycle between frames
        BUF_ONE = 1'b1
    } buf_mode_e;

    // order in which the words of a frame leave
    typedef enum logic [0:0]
    {
        // word 0 goes out first
        ORDER_LO_FIRST = 1'b0,
        // word els_p-1 goes out first
        ORDER_HI_FIRST = 1'b1
    } order_e;

    // default word width and words per frame
    localparam int width_dflt_c = 8;
    localparam int els_dflt_c   = 4;

endpackage

// File: fifo_if.sv
// fifo bus: enqueue and dequeue signals of one small buffer
`timescale 1ns/1ps

interface fifo_if
#(
    parameter int width_p = 8
);

    // enqueue side, ready-and-valid
    logic               enq_v;
    logic               enq_ready;
    logic [width_p-1:0] enq_data;

    // dequeue side, valid-then-yumi
    logic               deq_v;
    logic [width_p-1:0] deq_data;
    // only raised while deq_v is high
    logic               deq_yumi;

    // block that fills and drains the buffer
    modport owner
    (
        output enq_v,
        output enq_data,
        output deq_yumi,
        input  enq_ready,
        input  deq_v,
        input  deq_data
    );

    // the buffer itself
    modport buffer
    (
        input  enq_v,
        input  enq_data,
        input  deq_yumi,
        output enq_ready,
        output deq_v,
        output deq_data
    );

endinterface

// File: piso_one_fifo.sv
// single-entry buffer, accepts a word only while empty
`timescale 1ns/1ps

module piso_one_fifo
#(
    parameter int width_p = 8
)
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    fifo_if.buffer bus
);

    // held word and its occupancy flag
    logic [width_p-1:0] data_r;
    logic               full_r;
    logic               enq;

    assign enq = bus.enq_v & ~full_r;

    // not ready while holding a word, even if it leaves this cycle
    assign bus.enq_ready = ~full_r;
    assign bus.deq_v     = full_r;
    assign bus.deq_data  = data_r;

    always_ff @(posedge clk_i)
    begin
        if (enq)
        begin
            data_r <= bus.enq_data;
        end
    end

    // enq and yumi never meet: one needs empty, the other full
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            full_r <= 1'b0;
        end
        else if (enq)
        begin
            full_r <= 1'b1;
        end
        else if (bus.deq_yumi)
        begin
            full_r <= 1'b0;
        end
    end

endmodule

// File: piso_two_fifo.sv
// two-entry buffer that is ready while a slot is free so frames go back to back
`timescale 1ns/1ps

module piso_two_fifo
#(
    parameter int width_p = 8
)
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    fifo_if.buffer bus
);

    // storage slots
    logic [width_p-1:0] mem_r [2];
    // write and read slot pointers
    logic               wptr_r;
    logic               rptr_r;
    // occupancy tracking
    logic               full_r;
    logic               empty_r;
    logic               enq;
    logic               deq;

    // a free slot is enough, even when a word leaves this cycle
    assign bus.enq_ready = ~full_r;
    assign bus.deq_v     = ~empty_r;
    assign bus.deq_data  = mem_r[rptr_r];

    assign enq = bus.enq_v & ~full_r;
    // yumi only arrives while deq_v is high
    assign deq = bus.deq_yumi;

    always_ff @(posedge clk_i)
    begin
        if (enq)
        begin
            mem_r[wptr_r] <= bus.enq_data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wptr_r  <= 1'b0;
            rptr_r  <= 1'b0;
            full_r  <= 1'b0;
            empty_r <= 1'b1;
        end
        else
        begin
            if (enq)
            begin
                wptr_r <= ~wptr_r;
            end
            if (deq)
            begin
                rptr_r <= ~rptr_r;
            end
            // simultaneous enq and deq keeps the occupancy
            if (enq && !deq)
            begin
                empty_r <= 1'b0;
                full_r  <= (~wptr_r == rptr_r);
            end
            else if (deq && !enq)
            begin
                full_r  <= 1'b0;
                empty_r <= (~rptr_r == wptr_r);
            end
        end
    end

endmodule

// File: piso_serializer.sv
// piso serializer: reorders a frame, buffers it and shifts it out one word per yumi
`timescale 1ns/1ps

module piso_serializer
#(
    parameter int                  width_p    = piso_pkg::width_dflt_c,
    parameter int                  els_p      = piso_pkg::els_dflt_c,
    parameter piso_pkg::buf_mode_e buf_mode_p = piso_pkg::BUF_TWO,
    parameter piso_pkg::order_e    order_p    = piso_pkg::ORDER_LO_FIRST
)
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  logic [els_p*width_p-1:0] data_i,
    output logic                     ready_and_o,
    output logic                     valid_o,
    output logic [width_p-1:0]       data_o,
    input  logic                     yumi_i
);

    // frame in sending order, word 0 leaves first
    logic [els_p*width_p-1:0] data_li;
    // both buffers load on the same edge
    logic                     enq_v;

    // last word in sending order
    fifo_if #(.width_p(width_p)) last_if ();

    // word reversal for high-word-first
    if (order_p == piso_pkg::ORDER_HI_FIRST)
    begin : g_hi_first
        for (genvar k = 0; k < els_p; k++)
        begin : g_rev
            assign data_li[k*width_p +: width_p] = data_i[(els_p-1-k)*width_p +: width_p];
        end
    end
    else
    begin : g_lo_first
        assign data_li = data_i;
    end

    // last-word buffer, two entries avoid the bubble between frames
    if (buf_mode_p == piso_pkg::BUF_TWO)
    begin : g_last_two
        piso_two_fifo #(.width_p(width_p)) u_last_fifo
        (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .bus      (last_if)
        );
    end
    else
    begin : g_last_one
        piso_one_fifo #(.width_p(width_p)) u_last_fifo
        (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .bus      (last_if)
        );
    end

    assign enq_v            = valid_i & ready_and_o;
    assign last_if.enq_v    = enq_v;
    assign last_if.enq_data = data_li[(els_p-1)*width_p +: width_p];
    // output is valid exactly while the last word is still held
    assign valid_o          = last_if.deq_v;

    if (els_p == 1)
    begin : g_bypass
        // single word frames pass straight through the last-word buffer
        assign ready_and_o      = last_if.enq_ready;
        assign data_o           = last_if.deq_data;
        assign last_if.deq_yumi = yumi_i;
    end
    else
    begin : g_shift
        localparam int cnt_w_lp = $clog2(els_p);

        // index of the word on data_o
        logic [cnt_w_lp-1:0]      shift_ctr_r;
        logic                     last_yumi;
        logic                     rest_yumi;
        // whole frame rebuilt from both buffers
        logic [els_p*width_p-1:0] frame_lo;

        // remaining words, valid whenever last_if is valid before the end
        fifo_if #(.width_p((els_p-1)*width_p)) rest_if ();

        piso_one_fifo #(.width_p((els_p-1)*width_p)) u_rest_fifo
        (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .bus      (rest_if)
        );

        // enqueue only when both buffers have room
        assign ready_and_o      = last_if.enq_ready & rest_if.enq_ready;
        assign rest_if.enq_v    = enq_v;
        assign rest_if.enq_data = data_li[(els_p-1)*width_p-1:0];

        // free the rest buffer early, on the second-last word
        assign last_yumi        = yumi_i && (shift_ctr_r == cnt_w_lp'(els_p-1));
        assign rest_yumi        = yumi_i && (shift_ctr_r == cnt_w_lp'(els_p-2));
        assign last_if.deq_yumi = last_yumi;
        assign rest_if.deq_yumi = rest_yumi;

        // word select
        assign frame_lo = {last_if.deq_data, rest_if.deq_data};
        assign data_o   = frame_lo[shift_ctr_r*width_p +: width_p];

        // clears when the frame is done, otherwise counts taken words
        always_ff @(posedge clk_i or negedge arst_n_i)
        begin
            if (!arst_n_i)
            begin
                shift_ctr_r <= '0;
            end
            else if (last_yumi)
            begin
                shift_ctr_r <= '0;
            end
            else if (yumi_i)
            begin
                shift_ctr_r <= shift_ctr_r + 1'b1;
            end
        end
    end

endmodule

// File: piso_top.sv
// piso top: parallel-in serial-out word serializer with plain handshake ports
`timescale 1ns/1ps

module piso_top
#(
    parameter int                  width_p    = piso_pkg::width_dflt_c,
    parameter int                  els_p      = piso_pkg::els_dflt_c,
    parameter piso_pkg::buf_mode_e buf_mode_p = piso_pkg::BUF_TWO,
    parameter piso_pkg::order_e    order_p    = piso_pkg::ORDER_LO_FIRST
)
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    // input frame, ready-and-valid
    // word k sits at bits k*width_p upward
    input  logic                     valid_i,
    input  logic [els_p*width_p-1:0] data_i,
    output logic                     ready_and_o,

    // output words, valid-then-yumi
    output logic                     valid_o,
    output logic [width_p-1:0]       data_o,
    input  logic                     yumi_i
);

    piso_serializer
    #(
        .width_p    (width_p),
        .els_p      (els_p),
        .buf_mode_p (buf_mode_p),
        .order_p    (order_p)
    )
    u_serializer
    (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_i),
        .data_i      (data_i),
        .ready_and_o (ready_and_o),
        .valid_o     (valid_o),
        .data_o      (data_o),
        .yumi_i      (yumi_i)
    );

endmodule

// File: tb_piso_sva.sv
// piso assertions: output handshake, hold under back-pressure and idle in reset
`timescale 1ns/1ps

module piso_sva
#(
    parameter int width_p = piso_pkg::width_dflt_c
)
(
    input logic               clk_i,
    input logic               arst_n_i,
    input logic               valid_o,
    input logic               yumi_i,
    input logic [width_p-1:0] data_o
);

    // yumi only while a word is offered
    yumi_needs_valid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        yumi_i |-> valid_o
    ) else $error("yumi_i high without valid_o");

    // an offered word stays put until taken
    word_held: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !yumi_i |=> valid_o && $stable(data_o)
    ) else $error("data_o or valid_o changed while yumi_i was low");

    // nothing offered during reset
    idle_in_reset: assert property (
        @(posedge clk_i)
        !arst_n_i |-> !valid_o
    ) else $error("valid_o high during reset");

endmodule

bind piso_top piso_sva #(.width_p(width_p)) u_sva
(
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_o  (valid_o),
    .yumi_i   (yumi_i),
    .data_o   (data_o)
);

// File: tb_piso.sv
// piso testbench driving random frames through the serializer against a word-order reference
`timescale 1ns/1ps

module tb_piso
#(
    parameter int width_p    = piso_pkg::width_dflt_c,
    parameter int els_p      = piso_pkg::els_dflt_c,
    // 0 selects BUF_TWO, 1 selects BUF_ONE
    parameter int buf_mode_p = 0,
    // 0 selects ORDER_LO_FIRST, 1 selects ORDER_HI_FIRST
    parameter int order_p    = 0
);

    localparam int                  frame_w_lp  = els_p * width_p;
    localparam piso_pkg::buf_mode_e buf_mode_lp = piso_pkg::buf_mode_e'(buf_mode_p);
    localparam piso_pkg::order_e    order_lp    = piso_pkg::order_e'(order_p);
    localparam int                  timeout_lp  = 200;
    localparam int                  rand_frames_lp  = 60;
    localparam int                  burst_frames_lp = 20;

    // consumer behaviour on the output side
    localparam logic [1:0] take_rand_lp = 2'd0;
    localparam logic [1:0] take_all_lp  = 2'd1;
    localparam logic [1:0] take_none_lp = 2'd2;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic [frame_w_lp-1:0] in_data;
    logic                  in_ready;
    logic                  out_valid;
    logic [width_p-1:0]    out_data;
    logic                  out_yumi;
    logic                  take_r;
    logic [1:0]            take_mode;

    // scoreboard state
    logic [frame_w_lp-1:0] frame_q [$];
    int                    word_pos = 0;
    int                    words_checked = 0;
    int                    errors = 0;
    int                    timeouts = 0;

    piso_top
    #(
        .width_p    (width_p),
        .els_p      (els_p),
        .buf_mode_p (buf_mode_lp),
        .order_p    (order_lp)
    )
    u_dut
    (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .valid_i     (in_valid),
        .data_i      (in_data),
        .ready_and_o (in_ready),
        .valid_o     (out_valid),
        .data_o      (out_data),
        .yumi_i      (out_yumi)
    );

    // yumi follows valid, so the consumer never takes from an empty output
    assign out_yumi = take_r & out_valid;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected word at sending position pos of a frame
    function automatic logic [width_p-1:0] expected_word(input logic [frame_w_lp-1:0] frame,
                                                         input int pos);
        int k;
        // high-word-first starts with word els_p-1
        if (order_lp == piso_pkg::ORDER_HI_FIRST)
            k = els_p - 1 - pos;
        else
            k = pos;
        return frame[k*width_p +: width_p];
    endfunction

    function automatic logic [frame_w_lp-1:0] random_frame();
        logic [frame_w_lp-1:0] f;
        int k;
        for (k = 0; k < els_p; k++)
            f[k*width_p +: width_p] = width_p'($urandom);
        return f;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // called on a rising edge, returns on the edge where the offered frame is accepted
    task automatic await_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!(in_valid && in_ready) && waited < timeout_lp)
        begin
            @(posedge clk);
            waited++;
        end
        if (!(in_valid && in_ready))
        begin
            timeouts++;
            $display("timeout at %0t ns: a frame was offered but never accepted", $time);
        end
    endtask

    // idle cycles with valid low, then offer the frame until it is taken
    task automatic send_frame(input logic [frame_w_lp-1:0] frame, input int idle);
        if (idle > 0)
        begin
            in_valid <= 1'b0;
            repeat (idle) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= frame;
        await_accept();
    endtask

    // wait until every buffered word has left
    task automatic drain_output();
        int waited;
        waited = 0;
        @(posedge clk);
        while (out_valid && waited < timeout_lp)
        begin
            @(posedge clk);
            waited++;
        end
        if (out_valid)
        begin
            timeouts++;
            $display("timeout at %0t ns: the output never drained", $time);
        end
    endtask

    // consumer stalled, buffers fill and the next frame must wait unchanged
    task automatic stall_test();
        logic [frame_w_lp-1:0] first;
        logic [frame_w_lp-1:0] held;
        first = random_frame();
        held  = random_frame();
        take_mode <= take_none_lp;
        send_frame(first, 0);
        in_valid <= 1'b1;
        in_data  <= held;
        repeat (8)
        begin
            @(posedge clk);
            check_eq(in_ready, 1'b0, "ready_and_o while buffers are full");
            check_eq(out_valid, 1'b1, "valid_o while stalled");
            check_eq(out_data, expected_word(first, 0), "data_o while stalled");
        end
        take_mode <= take_all_lp;
        await_accept();
        in_valid <= 1'b0;
    endtask

    // back-to-back frames with a greedy consumer
    task automatic burst_test();
        int i;
        int taken;
        int waited;
        bit started;
        take_mode <= take_all_lp;
        fork
            begin
                for (i = 0; i < burst_frames_lp; i++)
                    send_frame(random_frame(), 0);
                in_valid <= 1'b0;
            end
            begin
                taken   = 0;
                waited  = 0;
                started = 1'b0;
                while (taken < burst_frames_lp * els_p && waited < 4 * burst_frames_lp * els_p)
                begin
                    @(posedge clk);
                    waited++;
                    // the two-entry buffer leaves no bubble between frames
                    if (started && buf_mode_lp == piso_pkg::BUF_TWO)
                        check_eq(out_valid, 1'b1, "valid_o gap during burst");
                    if (out_valid)
                        started = 1'b1;
                    if (out_valid && out_yumi)
                        taken++;
                end
                if (taken < burst_frames_lp * els_p)
                begin
                    timeouts++;
                    $display("timeout at %0t ns: burst words did not all come out", $time);
                end
            end
        join
    endtask

    // consumer picks a yumi request per cycle
    always @(posedge clk)
    begin
        case (take_mode)
            take_all_lp:  take_r <= 1'b1;
            take_none_lp: take_r <= 1'b0;
            default:      take_r <= ($urandom_range(0, 3) != 0);
        endcase
    end

    // scoreboard queues accepted frames and compares every taken word
    always @(posedge clk)
    begin
        if (arst_n)
        begin
            if (in_valid && in_ready)
                frame_q.push_back(in_data);
            if (out_valid && out_yumi)
            begin
                if (frame_q.size() == 0)
                begin
                    errors++;
                    $display("word taken at %0t ns while no frame was pending", $time);
                end
                else
                begin
                    check_eq(out_data, expected_word(frame_q[0], word_pos), "data_o word");
                    words_checked++;
                    word_pos++;
                    if (word_pos == els_p)
                    begin
                        void'(frame_q.pop_front());
                        word_pos = 0;
                    end
                end
            end
        end
    end

    initial
    begin
        int i;
        void'($urandom(32'h7e70));
        arst_n    = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        take_r    = 1'b0;
        take_mode = take_rand_lp;
        // reset falls after time zero so the asynchronous flops see an edge
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_eq(out_valid, 1'b0, "valid_o after reset");
        check_eq(in_ready, 1'b1, "ready_and_o after reset");
        // random gaps on both sides
        for (i = 0; i < rand_frames_lp; i++)
            send_frame(random_frame(), $urandom_range(0, 3));
        in_valid <= 1'b0;
        drain_output();
        stall_test();
        drain_output();
        burst_test();
        drain_output();
        @(negedge clk);
        check_eq(frame_q.size(), 0, "frames still pending at the end");
        $display("summary: %0d mismatches, %0d timeouts, %0d words compared",
                 errors, timeouts, words_checked);
        if (errors == 0 && timeouts == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: list.f
piso_pkg.sv
fifo_if.sv
piso_one_fifo.sv
piso_two_fifo.sv
piso_serializer.sv
piso_top.sv
tb_piso_sva.sv
tb_piso.sv

// File: run.sh
#!/bin/sh
# build and run the piso testbench with Verilator in two configurations
cd "$(dirname "$0")" || exit 1

run_cfg()
{
    cfg=$1
    shift
    verilator --binary --timing --assert -Wno-fatal --top-module tb_piso \
        --Mdir "obj_$cfg" "$@" -f list.f > "sim_$cfg.log" 2>&1 &&
        "./obj_$cfg/Vtb_piso" >> "sim_$cfg.log" 2>&1 ||
        echo "CHECKS FAILED" >> "sim_$cfg.log"
    ! grep -q "CHECKS FAILED" "sim_$cfg.log"
}

run_cfg two_lo -Gbuf_mode_p=0 -Gorder_p=0 &&
    run_cfg one_hi -Gbuf_mode_p=1 -Gorder_p=1 &&
    echo "both configurations passed" ||
    { echo "simulation failed, see sim_*.log"; exit 1; }
